// ==== Bender.yml ====
package:
  name: cpu16

sources:
  - include_dirs:
      - design
    files:
      - design/cpuPkg.sv
      - design/ctrlIf.sv
      - design/microSequencer.sv
      - design/regFile.sv
      - design/aluUnit.sv
      - design/cpuTop.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/cpuTb.sv

// ==== design/aluUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluUnit (
	input  logic         clock,
	input  logic         rstN,
	input  cpuPkg::wordT aBus,
	input  cpuPkg::wordT memRData,
	output cpuPkg::wordT yBus,
	output cpuPkg::wordT bReg,
	ctrlIf.alu           ctl
);

	localparam int W = $bits(cpuPkg::wordT);

	cpuPkg::wordT aluRes;
	cpuPkg::wordT shiftRes;
	logic aluC;
	logic shiftC;

	always_ff @(posedge clock) begin
		if (ctl.ctrl.bLoad) begin
			bReg <= aBus; // second operand or store data
		end
	end

	always_comb begin
		aluRes = aBus;
		aluC = 1'b0; // logic ops clear carry
		case (ctl.ctrl.aluFunc)
			cpuPkg::aluAdd: {aluC, aluRes} = {1'b0, aBus} + {1'b0, bReg};
			cpuPkg::aluSub: begin
				aluRes = aBus - bReg;
				aluC = (aBus >= bReg); // set when no borrow
			end
			cpuPkg::aluAnd: aluRes = aBus & bReg;
			cpuPkg::aluOr:  aluRes = aBus | bReg;
			cpuPkg::aluXor: aluRes = aBus ^ bReg;
			default: ;
		endcase
	end

	// one-bit shifter, bit shifted out goes to carry
	always_comb begin
		if (ctl.ctrl.aluFunc == cpuPkg::aluShr) begin
			shiftRes = {1'b0, aBus[W-1:1]};
			shiftC = aBus[0];
		end else begin
			shiftRes = {aBus[W-2:0], 1'b0};
			shiftC = aBus[W-1];
		end
	end

	always_comb begin
		case (ctl.ctrl.ySrc)
			cpuPkg::ySrcAlu:   yBus = aluRes;
			cpuPkg::ySrcShift: yBus = shiftRes;
			cpuPkg::ySrcMem:   yBus = memRData;
			default:           yBus = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			ctl.carry <= 1'b0;
			ctl.zero <= 1'b0;
		end else if (ctl.ctrl.statusLoad) begin
			ctl.carry <= (ctl.ctrl.ySrc == cpuPkg::ySrcShift) ? shiftC : aluC;
			ctl.zero <= (yBus == '0);
		end
	end

	assert property (@(posedge clock) disable iff (!rstN)
		ctl.ctrl.statusLoad |->
			(ctl.ctrl.ySrc == cpuPkg::ySrcAlu || ctl.ctrl.ySrc == cpuPkg::ySrcShift))
		else $error("status load with a non-ALU result on Y");

endmodule

`default_nettype wire

// ==== design/cpuPkg.sv ====
`include "cpu_cfg.svh"
`default_nettype none

package cpuPkg;

	typedef logic [`CPU_DATA_W-1:0] wordT; // one machine word
	typedef logic [$clog2(`CPU_NUM_REGS)-1:0] regIdxT; // register number

	// instruction word is {opcode[6:0], op0[2:0], op1[2:0], op2[2:0]}
	typedef enum logic [6:0] {
		opNop  = 7'h00, // also the IR value out of reset
		opAdd  = 7'h01,
		opSub  = 7'h02,
		opAnd  = 7'h03,
		opOr   = 7'h04,
		opXor  = 7'h05,
		opShl  = 7'h06,
		opShr  = 7'h07,
		opLdi  = 7'h08, // operand in next word
		opLd   = 7'h09,
		opSt   = 7'h0a,
		opJmp  = 7'h0b, // target in next word
		opJz   = 7'h0c,
		opJc   = 7'h0d,
		opHalt = 7'h7f
	} opcodeE;

	typedef enum logic [4:0] {
		aluAdd = 5'h00,
		aluSub = 5'h01,
		aluAnd = 5'h02,
		aluOr  = 5'h03,
		aluXor = 5'h04,
		aluShl = 5'h10, // shifter functions
		aluShr = 5'h11
	} aluFuncE;

	typedef enum logic [1:0] {
		ySrcAlu   = 2'd0,
		ySrcShift = 2'd1,
		ySrcMem   = 2'd2
	} ySrcE;

	typedef enum logic [1:0] {
		regSrcMicro = 2'd0, // register number from the control word
		regSrcOp0   = 2'd1,
		regSrcOp1   = 2'd2,
		regSrcOp2   = 2'd3
	} regSrcE;

	typedef struct packed {
		logic    rdEn;   // drive A bus from a register
		regSrcE  rdSrc;
		regIdxT  rdSel;
		logic    wrEn;   // load a register from Y bus
		regSrcE  wrSrc;
		regIdxT  wrSel;
		logic    pcInc;
		logic    bLoad;
		aluFuncE aluFunc;
		ySrcE    ySrc;
		logic    statusLoad;
		logic    memRead;
		logic    memWrite;
		logic    irLoad;
	} ctrlWordS;

endpackage

`default_nettype wire

// ==== design/cpuTop.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"
`default_nettype none

module cpuTop (
	input  logic                   clock,
	input  logic                   rstN,
	output logic [`CPU_DATA_W-1:0] memAddr,
	output logic [`CPU_DATA_W-1:0] memWData,
	input  logic [`CPU_DATA_W-1:0] memRData,
	output logic                   memRead,
	output logic                   memWrite,
	output logic                   halted
);

	cpuPkg::wordT aBus; // register and address values
	cpuPkg::wordT yBus; // ALU, shift and memory results
	cpuPkg::wordT bReg;

	ctrlIf ctl ();

	microSequencer seq (
		.clock  (clock),
		.rstN   (rstN),
		.yBus   (yBus),
		.halted (halted),
		.ctl    (ctl.seq)
	);

	regFile regs (
		.clock (clock),
		.rstN  (rstN),
		.aBus  (aBus),
		.yBus  (yBus),
		.ctl   (ctl.regs)
	);

	aluUnit alu (
		.clock    (clock),
		.rstN     (rstN),
		.aBus     (aBus),
		.memRData (memRData),
		.yBus     (yBus),
		.bReg     (bReg),
		.ctl      (ctl.alu)
	);

	// memory sees the A bus as address and B as write data
	assign memAddr = aBus;
	assign memWData = bReg;
	assign memRead = ctl.ctrl.memRead;
	assign memWrite = ctl.ctrl.memWrite;

endmodule

`default_nettype wire

// ==== design/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath sizing
`define CPU_DATA_W   16 // data and word address width
`define CPU_NUM_REGS 8  // r0..r6 plus pc

// r7 doubles as the program counter
`define CPU_PC_REG   7

// micro-step counter, far more than the longest instruction needs
`define CPU_UPC_W    6

`endif

// ==== design/ctrlIf.sv ====
`timescale 1ns/10ps
`default_nettype none

interface ctrlIf;

	cpuPkg::ctrlWordS ctrl; // control word of the current micro-step
	cpuPkg::regIdxT op0;    // IR register fields
	cpuPkg::regIdxT op1;
	cpuPkg::regIdxT op2;
	logic carry;            // status flags back to the sequencer
	logic zero;

	modport seq (
		output ctrl,
		output op0,
		output op1,
		output op2,
		input  carry,
		input  zero
	);

	modport regs (
		input ctrl,
		input op0,
		input op1,
		input op2
	);

	modport alu (
		input  ctrl,
		output carry,
		output zero
	);

endinterface

`default_nettype wire

// ==== design/microSequencer.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"
`default_nettype none

module microSequencer (
	input  logic         clock,
	input  logic         rstN,
	input  cpuPkg::wordT yBus,
	output logic         halted,
	ctrlIf.seq           ctl
);

	localparam logic [`CPU_UPC_W-1:0] StepFetch = '0;
	localparam logic [`CPU_UPC_W-1:0] Step1 = 1;
	localparam logic [`CPU_UPC_W-1:0] Step2 = 2;
	localparam cpuPkg::regIdxT PcIdx = `CPU_PC_REG;

	cpuPkg::wordT ir;
	logic [`CPU_UPC_W-1:0] uPc; // step within the instruction
	logic running;              // low for the cycle leaving reset
	logic lastStep;
	logic taken;
	logic isShift;
	cpuPkg::opcodeE opcode;
	cpuPkg::aluFuncE opFunc;
	cpuPkg::ctrlWordS uWord;

	assign opcode = cpuPkg::opcodeE'(ir[15:9]);
	assign ctl.op0 = ir[8:6];
	assign ctl.op1 = ir[5:3];
	assign ctl.op2 = ir[2:0];

	assign isShift = (opcode == cpuPkg::opShl) || (opcode == cpuPkg::opShr);
	assign taken = (opcode == cpuPkg::opJmp) ||
		(opcode == cpuPkg::opJz && ctl.zero) ||
		(opcode == cpuPkg::opJc && ctl.carry);

	always_comb begin
		case (opcode)
			cpuPkg::opSub: opFunc = cpuPkg::aluSub;
			cpuPkg::opAnd: opFunc = cpuPkg::aluAnd;
			cpuPkg::opOr:  opFunc = cpuPkg::aluOr;
			cpuPkg::opXor: opFunc = cpuPkg::aluXor;
			cpuPkg::opShl: opFunc = cpuPkg::aluShl;
			cpuPkg::opShr: opFunc = cpuPkg::aluShr;
			default:       opFunc = cpuPkg::aluAdd;
		endcase
	end

	// microcode table, indexed by opcode and step
	always_comb begin
		uWord = '0;
		lastStep = 1'b1;
		if (uPc == StepFetch) begin
			lastStep = 1'b0; // execution steps follow
			uWord.rdEn = 1'b1; // pc is the fetch address
			uWord.rdSel = PcIdx;
			uWord.memRead = 1'b1;
			uWord.ySrc = cpuPkg::ySrcMem;
			uWord.irLoad = 1'b1;
			uWord.pcInc = 1'b1;
		end else begin
			case (opcode)
				cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr,
				cpuPkg::opXor, cpuPkg::opShl, cpuPkg::opShr: begin
					lastStep = (uPc == Step2);
					uWord.rdEn = 1'b1;
					if (uPc == Step1) begin
						uWord.rdSrc = cpuPkg::regSrcOp2; // op2 into B
						uWord.bLoad = 1'b1;
					end else begin
						uWord.rdSrc = cpuPkg::regSrcOp1;
						uWord.aluFunc = opFunc;
						uWord.ySrc = isShift ? cpuPkg::ySrcShift : cpuPkg::ySrcAlu;
						uWord.wrEn = 1'b1;
						uWord.wrSrc = cpuPkg::regSrcOp0;
						uWord.statusLoad = 1'b1;
					end
				end
				cpuPkg::opLdi: begin
					uWord.rdEn = 1'b1; // immediate sits at pc
					uWord.rdSel = PcIdx;
					uWord.memRead = 1'b1;
					uWord.ySrc = cpuPkg::ySrcMem;
					uWord.wrEn = 1'b1;
					uWord.wrSrc = cpuPkg::regSrcOp0;
					uWord.pcInc = 1'b1;
				end
				cpuPkg::opLd: begin
					uWord.rdEn = 1'b1;
					uWord.rdSrc = cpuPkg::regSrcOp1; // address register
					uWord.memRead = 1'b1;
					uWord.ySrc = cpuPkg::ySrcMem;
					uWord.wrEn = 1'b1;
					uWord.wrSrc = cpuPkg::regSrcOp0;
				end
				cpuPkg::opSt: begin
					lastStep = (uPc == Step2);
					uWord.rdEn = 1'b1;
					if (uPc == Step1) begin
						uWord.rdSrc = cpuPkg::regSrcOp2; // store data via B
						uWord.bLoad = 1'b1;
					end else begin
						uWord.rdSrc = cpuPkg::regSrcOp1;
						uWord.memWrite = 1'b1;
					end
				end
				cpuPkg::opJmp, cpuPkg::opJz, cpuPkg::opJc: begin
					if (taken) begin
						uWord.rdEn = 1'b1; // target word at pc goes into pc
						uWord.rdSel = PcIdx;
						uWord.memRead = 1'b1;
						uWord.ySrc = cpuPkg::ySrcMem;
						uWord.wrEn = 1'b1;
						uWord.wrSel = PcIdx;
					end else begin
						uWord.pcInc = 1'b1; // skip the target word
					end
				end
				default: ; // nop and halt issue an idle word
			endcase
		end
	end

	assign ctl.ctrl = running ? uWord : '0;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			running <= 1'b0;
			uPc <= StepFetch;
			ir <= '0;
			halted <= 1'b0;
		end else begin
			running <= 1'b1;
			if (ctl.ctrl.irLoad) begin
				ir <= yBus;
			end
			if (running) begin
				if (opcode == cpuPkg::opHalt && uPc != StepFetch) begin
					halted <= 1'b1; // uPc stays put from here on
				end else if (lastStep) begin
					uPc <= StepFetch;
				end else begin
					uPc <= uPc + 1'b1;
				end
			end
		end
	end

	assert property (@(posedge clock) disable iff (!rstN)
		!(ctl.ctrl.memRead && ctl.ctrl.memWrite))
		else $error("memRead and memWrite high together");

	assert property (@(posedge clock) disable iff (!rstN)
		ctl.ctrl.irLoad |-> (uPc == StepFetch) ##1 (uPc == Step1))
		else $error("IR load outside the fetch step");

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"
`default_nettype none

module regFile (
	input  logic         clock,
	input  logic         rstN,
	output cpuPkg::wordT aBus,
	input  cpuPkg::wordT yBus,
	ctrlIf.regs          ctl
);

	localparam cpuPkg::regIdxT PcIdx = `CPU_PC_REG;

	cpuPkg::wordT gpr [0:`CPU_NUM_REGS-2]; // r0..r6
	cpuPkg::wordT pc;                      // r7
	cpuPkg::regIdxT rdIdx;
	cpuPkg::regIdxT wrIdx;
	logic pcWrite;

	function automatic cpuPkg::regIdxT pickReg(
		input cpuPkg::regSrcE src,
		input cpuPkg::regIdxT uSel,
		input cpuPkg::regIdxT op0,
		input cpuPkg::regIdxT op1,
		input cpuPkg::regIdxT op2
	);
		case (src)
			cpuPkg::regSrcOp0: pickReg = op0;
			cpuPkg::regSrcOp1: pickReg = op1;
			cpuPkg::regSrcOp2: pickReg = op2;
			default:           pickReg = uSel;
		endcase
	endfunction

	assign rdIdx = pickReg(ctl.ctrl.rdSrc, ctl.ctrl.rdSel, ctl.op0, ctl.op1, ctl.op2);
	assign wrIdx = pickReg(ctl.ctrl.wrSrc, ctl.ctrl.wrSel, ctl.op0, ctl.op1, ctl.op2);
	assign pcWrite = ctl.ctrl.wrEn && (wrIdx == PcIdx);

	// A bus reads as zero when nothing is selected
	always_comb begin
		if (!ctl.ctrl.rdEn) begin
			aBus = '0;
		end else if (rdIdx == PcIdx) begin
			aBus = pc;
		end else begin
			aBus = gpr[rdIdx];
		end
	end

	always_ff @(posedge clock) begin
		if (ctl.ctrl.wrEn && !pcWrite) begin
			gpr[wrIdx] <= yBus;
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			pc <= '0;
		end else if (pcWrite) begin
			pc <= yBus; // jump
		end else if (ctl.ctrl.pcInc) begin
			pc <= pc + 1'b1;
		end
	end

	assert property (@(posedge clock) disable iff (!rstN)
		!(ctl.ctrl.pcInc && pcWrite))
		else $error("pc increment and pc write in one cycle");

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+design
design/cpuPkg.sv
design/ctrlIf.sv
design/microSequencer.sv
design/regFile.sv
design/aluUnit.sv
design/cpuTop.sv
tb/cpuTb.sv

// ==== tb/cpuTb.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"
`default_nettype none

module cpuTb;

	typedef logic [`CPU_DATA_W-1:0] wordT;

	localparam int MemWords = 4096;

	logic clock = 1'b0;
	logic rstN = 1'b0;
	wordT memAddr;
	wordT memWData;
	wordT memRData;
	logic memRead;
	logic memWrite;
	logic halted;

	wordT mem [0:MemWords-1];    // memory seen by the DUT
	wordT img [0:MemWords-1];    // program image under construction
	wordT refMem [0:MemWords-1]; // memory of the reference run
	int emitPtr;
	logic [31:0] lcgState = 32'hbfcc9a79;
	int cycles = 0;
	int cycleLimit = 100; // grows as each test registers its length
	int writesAfterHalt = 0;
	int checks = 0;
	int errors = 0;
	int testErrors = 0;
	int testCount = 0;
	bit compareReq = 1'b0;

	cpuTop uut (
		.clock    (clock),
		.rstN     (rstN),
		.memAddr  (memAddr),
		.memWData (memWData),
		.memRData (memRData),
		.memRead  (memRead),
		.memWrite (memWrite),
		.halted   (halted)
	);

	always #10 clock = ~clock;

	assign memRData = mem[memAddr[11:0]]; // 4K words, asynchronous read

	always @(posedge clock) begin
		if (memWrite) begin
			mem[memAddr[11:0]] <= memWData;
			if (halted) begin
				writesAfterHalt <= writesAfterHalt + 1;
			end
		end
	end

	function automatic wordT randWord();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[31:16];
	endfunction

	function automatic wordT fillWord(input int addr);
		return 16'(addr * 32'h9e37) ^ 16'hc3a5; // odd multiplier, unique per address
	endfunction

	// ISA interpreter, runs on refMem and returns the executed instruction count
	function automatic int runReference();
		wordT r [0:7];
		wordT w;
		wordT a;
		wordT b;
		wordT res;
		logic c;
		logic z;
		logic aluOp;
		int n;
		bit done;
		for (int i = 0; i < 8; i++) begin
			r[i] = '0;
		end
		c = 1'b0;
		z = 1'b0;
		n = 0;
		done = 1'b0;
		while (!done && n < 5000) begin
			w = refMem[r[7][11:0]];
			r[7] = r[7] + 1'b1;
			n++;
			a = r[w[5:3]];
			b = r[w[2:0]];
			aluOp = 1'b1;
			res = '0;
			case (w[15:9])
				cpuPkg::opAdd: {c, res} = {1'b0, a} + {1'b0, b};
				cpuPkg::opSub: begin
					res = a - b;
					c = (a >= b); // no borrow
				end
				cpuPkg::opAnd: {c, res} = {1'b0, a & b};
				cpuPkg::opOr:  {c, res} = {1'b0, a | b};
				cpuPkg::opXor: {c, res} = {1'b0, a ^ b};
				cpuPkg::opShl: {c, res} = {a[15], a[14:0], 1'b0};
				cpuPkg::opShr: {c, res} = {a[0], 1'b0, a[15:1]};
				default: begin
					aluOp = 1'b0;
					case (w[15:9])
						cpuPkg::opLdi: begin
							r[w[8:6]] = refMem[r[7][11:0]];
							r[7] = r[7] + 1'b1;
						end
						cpuPkg::opLd: r[w[8:6]] = refMem[a[11:0]];
						cpuPkg::opSt: refMem[a[11:0]] = b;
						cpuPkg::opJmp: r[7] = refMem[r[7][11:0]];
						cpuPkg::opJz: r[7] = z ? refMem[r[7][11:0]] : r[7] + 1'b1;
						cpuPkg::opJc: r[7] = c ? refMem[r[7][11:0]] : r[7] + 1'b1;
						cpuPkg::opHalt: done = 1'b1;
						default: ;
					endcase
				end
			endcase
			if (aluOp) begin
				r[w[8:6]] = res;
				z = (res == '0);
			end
		end
		return n;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			testErrors++;
			$display("** Error %s: got %0h, expected %0h", name, got, exp);
		end
	endtask

	task automatic startProgram();
		for (int a = 0; a < MemWords; a++) begin
			img[a] = fillWord(a);
		end
		emitPtr = 0;
	endtask

	task automatic emit(input wordT word);
		img[emitPtr] = word;
		emitPtr++;
	endtask

	task automatic emitOp(input logic [6:0] op, input int d, input int a, input int b);
		emit({op, 3'(d), 3'(a), 3'(b)});
	endtask

	task automatic loadImm(input int rd, input wordT value);
		emitOp(cpuPkg::opLdi, rd, 0, 0);
		emit(value);
	endtask

	task automatic storeReg(input int rs, input wordT addr);
		loadImm(6, addr); // r6 is the address scratch
		emitOp(cpuPkg::opSt, 0, 6, rs);
	endtask

	// r5 ends up holding markTaken or markSkip, then goes to addr
	task automatic branchProbe(input logic [6:0] op, input wordT markTaken,
		input wordT markSkip, input wordT addr);
		loadImm(5, markTaken);
		emitOp(op, 0, 0, 0);
		emit(16'(emitPtr + 3)); // lands past the next LDI
		loadImm(5, markSkip);
		storeReg(5, addr);
	endtask

	task automatic flagProbes(input int rs, input wordT addr);
		storeReg(rs, addr);
		branchProbe(cpuPkg::opJc, 16'h00c1, 16'h00c0, addr + 1'b1);
		branchProbe(cpuPkg::opJz, 16'h00d1, 16'h00d0, addr + 2'd2);
	endtask

	task automatic aluPair(input logic [6:0] op, input wordT x, input wordT y);
		loadImm(1, x);
		loadImm(2, y);
		emitOp(op, 3, 1, 2);
	endtask

	task automatic buildAluProgram();
		logic [6:0] ops [0:4];
		ops = '{cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr, cpuPkg::opXor};
		startProgram();
		loadImm(1, randWord());
		loadImm(2, randWord());
		for (int k = 0; k < 5; k++) begin
			emitOp(ops[k], 3, 1, 2);
			storeReg(3, 16'h100 + k);
		end
		emitOp(cpuPkg::opHalt, 0, 0, 0);
	endtask

	task automatic buildShiftProgram();
		wordT vals [0:3];
		vals = '{randWord(), randWord(), 16'h8000, 16'h0001}; // last two shift to zero
		startProgram();
		for (int i = 0; i < 4; i++) begin
			loadImm(1, vals[i]);
			for (int s = 0; s < 2; s++) begin
				emitOp(s ? cpuPkg::opShr : cpuPkg::opShl, 2, 1, 1);
				flagProbes(2, 16'h200 + i * 8 + s * 4);
			end
		end
		emitOp(cpuPkg::opHalt, 0, 0, 0);
	endtask

	task automatic buildBranchProgram();
		wordT v;
		v = randWord();
		startProgram();
		branchProbe(cpuPkg::opJmp, 16'h00a1, 16'h00a0, 16'h300);
		aluPair(cpuPkg::opSub, v, v); // Z and C set
		flagProbes(3, 16'h304);
		aluPair(cpuPkg::opAdd, 16'h0001, 16'h0002); // both clear
		flagProbes(3, 16'h308);
		aluPair(cpuPkg::opAnd, 16'h00f0, 16'h0f00); // Z only
		flagProbes(3, 16'h30c);
		aluPair(cpuPkg::opAdd, 16'h8000, 16'h9000); // C only
		flagProbes(3, 16'h310);
		aluPair(cpuPkg::opXor, randWord(), randWord());
		flagProbes(3, 16'h314);
		emitOp(cpuPkg::opHalt, 0, 0, 0);
	endtask

	task automatic buildMemProgram();
		int src;
		int dst;
		startProgram();
		for (int i = 0; i < 6; i++) begin
			src = 16'h400 + i;
			dst = 16'h500 + (randWord() & 16'h00ff);
			img[src] = randWord();
			loadImm(1, src);
			emitOp(cpuPkg::opLd, 2, 1, 0);
			loadImm(3, dst);
			emitOp(cpuPkg::opSt, 0, 3, 2);
		end
		emitOp(cpuPkg::opHalt, 0, 0, 0);
	endtask

	// ten cycles of reset, outputs must stay quiet after the first edge
	task automatic holdReset(input bit loadImage);
		@(negedge clock);
		rstN = 1'b0;
		for (int i = 0; i < 10; i++) begin
			@(negedge clock);
			checkValue("halted", halted, 0);
			checkValue("memRead", memRead, 0);
			checkValue("memWrite", memWrite, 0);
			if (i == 0 && loadImage) begin
				mem = img;
				writesAfterHalt = 0;
			end
		end
		rstN = 1'b1;
	endtask

	task automatic waitHalted();
		while (halted !== 1'b1) begin
			@(negedge clock);
		end
	endtask

	task automatic finishTest(input string name, input int n);
		repeat (20) @(negedge clock); // window for stray writes after halt
		compareReq = 1'b1;
		wait (!compareReq);
		testCount++;
		$display("%-10s %0d instructions, %0d errors", name, n, testErrors);
	endtask

	task automatic runProgram(input string name);
		int n;
		refMem = img;
		n = runReference();
		cycleLimit += 10 * n + 80;
		testErrors = 0;
		holdReset(1'b1);
		waitHalted();
		finishTest(name, n);
	endtask

	task automatic resetTest();
		int n;
		int cut;
		buildAluProgram();
		refMem = img;
		n = runReference();
		cut = 20 + (randWord() % 16); // lands inside the run
		cycleLimit += cut + 10 * n + 100;
		testErrors = 0;
		holdReset(1'b1);
		repeat (cut) @(negedge clock);
		holdReset(1'b0); // memory keeps the partial run
		waitHalted();
		finishTest("midReset", n);
	endtask

	always begin
		wait (compareReq);
		for (int a = 0; a < MemWords; a++) begin
			checkValue($sformatf("mem[%03h]", a), mem[a], refMem[a]);
		end
		checkValue("writesAfterHalt", writesAfterHalt, 0);
		compareReq = 1'b0;
	end

	initial begin
		while (cycles <= cycleLimit) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: the core did not halt within %0d cycles", cycleLimit);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		buildAluProgram();
		runProgram("alu");
		buildShiftProgram();
		runProgram("shift");
		buildBranchProgram();
		runProgram("branch");
		buildMemProgram();
		runProgram("loadStore");
		resetTest();
		$display("%0d tests, %0d checks, %0d errors", testCount, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
